//--- cacheConfigPkg.sv
package cacheConfigPkg;

    // geometry: 4 ways x 16 sets of 16-byte lines
    localparam int numWays   = 4;
    localparam int numSets   = 16;
    localparam int lineBytes = 16;

    // victim LFSR start value, must be nonzero
    localparam logic [15:0] lfsrSeed = 16'h0001;

    typedef logic [31:0]                  addr_t;
    // addr[31:8] tag, addr[7:4] set, addr[3:0] byte in line
    typedef logic [23:0]                  tag_t;
    typedef logic [$clog2(numSets)-1:0]   setIndex_t;
    typedef logic [$clog2(lineBytes)-1:0] lineOffset_t;
    typedef logic [$clog2(numWays)-1:0]   way_t;
    typedef logic [lineBytes*8-1:0]       line_t;
    typedef logic [lineBytes-1:0]         lineStrobe_t;

    typedef enum logic [2:0] {
        idle, lookup, miss, replace, refill, writeResp
    } cacheState_e;

    typedef enum logic {
        opRead, opWrite
    } cacheOp_e;

    // write width, request must be aligned to it
    typedef enum logic [1:0] {
        sizeByte, sizeHalf, sizeWord, sizeDouble
    } accessSize_e;

endpackage

//--- axiBusPkg.sv
package axiBusPkg;

    // memory port moves 8 bytes per beat
    localparam int beatBytes = 8;

    // fixed incrementing burst, two beats fill one line
    localparam int beatsPerLine = 2;

    // one data beat, two words
    typedef logic [beatBytes*8-1:0] beat_t;

    // byte strobes, one per beat byte
    typedef logic [beatBytes-1:0] beatStrobe_t;

    // which half of the line a beat carries
    // 0 is the lower half
    typedef logic [$clog2(beatsPerLine)-1:0] beatIndex_t;

endpackage

//--- tagDirectory.sv
`timescale 1ns/100ps

module tagDirectory import cacheConfigPkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  setIndex_t lookupSet,
    input  tag_t      lookupTag,
    input  way_t      fillWay,
    input  logic      tagWrite,
    input  logic      validSet,
    input  logic      dirtySet,
    input  logic      dirtyClear,
    output logic      hit,
    output way_t      hitWay,
    output logic      victimDirty,
    output tag_t      victimTag
);

    // one tag array per way
    tag_t tagArray [numWays][numSets];
    // registered read of all four ways
    tag_t tagRead [numWays];

    // status bits indexed [set][way]
    logic [numSets-1:0][numWays-1:0] validBits;
    logic [numSets-1:0][numWays-1:0] dirtyBits;

    logic [numWays-1:0] wayHit;

    // synchronous read, set index held from idle into lookup
    always_ff @(posedge clock) begin
        for (int w = 0; w < numWays; w++) begin
            tagRead[w] <= tagArray[w][lookupSet];
        end
        // written on first refill beat
        // so the second beat reads it back
        if (tagWrite) begin
            tagArray[fillWay][lookupSet] <= lookupTag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            if (validSet) begin
                validBits[lookupSet][fillWay] <= 1'b1;
            end
            if (dirtyClear) begin
                dirtyBits[lookupSet][fillWay] <= 1'b0;
            end
            // store hit marks its own way
            if (dirtySet) begin
                dirtyBits[lookupSet][hitWay] <= 1'b1;
            end
        end
    end

    // parallel compare over the set
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < numWays; w++) begin
            wayHit[w] = validBits[lookupSet][w] && (tagRead[w] == lookupTag);
            // later ways override, highest match wins
            if (wayHit[w]) begin
                hitWay = way_t'(w);
            end
        end
    end

    assign hit = |wayHit;

    // victim status for the way picked by the controller
    assign victimDirty = validBits[lookupSet][fillWay] && dirtyBits[lookupSet][fillWay];
    assign victimTag   = tagRead[fillWay];

endmodule

//--- lineStore.sv
`timescale 1ns/100ps

module lineStore import cacheConfigPkg::*, axiBusPkg::*; (
    input  logic        clock,
    input  setIndex_t   lineSet,
    input  way_t        lineWay,
    input  lineOffset_t offset,
    input  accessSize_e size,
    input  beat_t       storeData,
    input  logic        storeWrite,
    input  logic        fillWrite,
    input  beatIndex_t  fillBeat,
    input  beat_t       fillData,
    output beat_t       readData,
    output line_t       readLine
);

    // 64 lines, addressed {set, way}
    line_t dataArray [numSets*numWays];

    logic [$clog2(numSets*numWays)-1:0] lineIndex;
    line_t       writeLine;
    lineStrobe_t writeMask;
    lineStrobe_t sizeMask;

    assign lineIndex = {lineSet, lineWay};

    // bytes covered by the access, before the offset shift
    always_comb begin
        case (size)
            sizeByte: sizeMask = lineStrobe_t'(16'h0001);
            sizeHalf: sizeMask = lineStrobe_t'(16'h0003);
            sizeWord: sizeMask = lineStrobe_t'(16'h000f);
            default:  sizeMask = lineStrobe_t'(16'h00ff);
        endcase
    end

    always_comb begin
        writeLine = '0;
        writeMask = '0;
        if (fillWrite) begin
            // beat goes to one half of the line
            writeLine = {fillData, fillData};
            writeMask = lineStrobe_t'({beatBytes{1'b1}}) << (fillBeat * beatBytes);
        end else if (storeWrite) begin
            // aligned store, shift data and enables to the byte offset
            writeLine = line_t'(storeData) << {offset, 3'b000};
            writeMask = sizeMask << offset;
        end
    end

    always_ff @(posedge clock) begin
        for (int b = 0; b < lineBytes; b++) begin
            if (writeMask[b]) begin
                dataArray[lineIndex][b*8 +: 8] <= writeLine[b*8 +: 8];
            end
        end
        // read lags the index by one cycle
        readLine <= dataArray[lineIndex];
    end

    // 64 bits from the offset on, zero filled past the line end
    assign readData = beat_t'(readLine >> {offset, 3'b000});

endmodule

//--- missController.sv
`timescale 1ns/100ps

module missController import cacheConfigPkg::*, axiBusPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        requestValid,
    input  cacheOp_e    requestOp,
    input  tag_t        requestTag,
    input  setIndex_t   requestSet,
    input  logic        hit,
    input  way_t        hitWay,
    input  logic        victimDirty,
    input  tag_t        victimTag,
    input  line_t       readLine,
    // read address and data channels
    output logic        arValid,
    input  logic        arReady,
    output addr_t       arAddr,
    input  logic        rValid,
    output logic        rReady,
    input  logic        rLast,
    // write address, data and response channels
    output logic        awValid,
    input  logic        awReady,
    output addr_t       awAddr,
    output logic        wValid,
    input  logic        wReady,
    output beat_t       wData,
    output beatStrobe_t wStrb,
    output logic        wLast,
    input  logic        bValid,
    output logic        bReady,
    // directory and store control
    output logic        tagWrite,
    output logic        validSet,
    output logic        dirtySet,
    output logic        dirtyClear,
    output way_t        fillWay,
    output way_t        lineWay,
    output logic        storeWrite,
    output logic        fillWrite,
    output beatIndex_t  fillBeat,
    output logic        dataOk
);

    cacheState_e state;
    cacheState_e nextState;

    logic [15:0] lfsr;
    beatIndex_t  beatCount;
    logic        lookupHit;
    logic        lookupMiss;

    assign lookupHit  = (state == lookup) && hit;
    assign lookupMiss = (state == lookup) && !hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            // dataOk cycle still sees the old request, skip it
            idle:      if (requestValid && !dataOk) nextState = lookup;
            lookup:    nextState = hit ? idle : miss;
            miss: begin
                if (awValid && awReady) begin
                    nextState = replace;
                end else if (arValid && arReady) begin
                    nextState = refill;
                end
            end
            replace:   if (wValid && wReady && wLast) nextState = writeResp;
            // any response ends the write-back, refill follows
            writeResp: if (bValid) nextState = miss;
            refill:    if (rValid && rLast) nextState = lookup;
            default:   nextState = idle;
        endcase
    end

    // x^16 + x^14 + x^13 + x^11 Fibonacci, shifting right
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= lfsrSeed;
        end else begin
            lfsr <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        end
    end

    // victim picked once, on the lookup that misses
    always_ff @(posedge clock) begin
        if (reset) begin
            fillWay <= '0;
        end else if (lookupMiss) begin
            fillWay <= way_t'(lfsr);
        end
    end

    // beat position in the current burst
    always_ff @(posedge clock) begin
        if (reset) begin
            beatCount <= '0;
        end else if ((awValid && awReady) || (arValid && arReady)) begin
            beatCount <= '0;
        end else if ((wValid && wReady) || (rValid && rReady)) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dataOk <= 1'b0;
        end else begin
            dataOk <= lookupHit;
        end
    end

    // dirty victim goes out first, clean victim refills at once
    assign awValid = (state == miss) && victimDirty;
    assign arValid = (state == miss) && !victimDirty;
    assign awAddr  = {victimTag, requestSet, 4'b0000};
    assign arAddr  = {requestTag, requestSet, 4'b0000};

    // victim line already sits in readLine by replace
    assign wValid = (state == replace);
    assign wData  = beatCount[0] ? readLine[127:64] : readLine[63:0];
    assign wStrb  = '1;
    assign wLast  = (beatCount == beatIndex_t'(beatsPerLine - 1));
    assign bReady = (state == writeResp);
    assign rReady = (state == refill);

    // hits use the hit way, everything else the victim
    assign lineWay    = (state == lookup) ? hitWay : fillWay;
    assign storeWrite = lookupHit && (requestOp == opWrite);
    assign dirtySet   = storeWrite;

    assign fillWrite = (state == refill) && rValid;
    assign fillBeat  = beatCount;
    // tag early so lookup can read it back
    assign tagWrite  = fillWrite && (beatCount == '0);
    assign validSet  = fillWrite && rLast;
    // written back, or fresh line from memory
    assign dirtyClear = ((state == writeResp) && bValid) || validSet;

endmodule

//--- dataCache.sv
`timescale 1ns/100ps

module dataCache import cacheConfigPkg::*, axiBusPkg::*; (
    input  logic        clock,
    input  logic        reset,
    // requester side
    input  logic        requestValid,
    input  cacheOp_e    requestOp,
    input  addr_t       requestAddr,
    input  accessSize_e requestSize,
    input  beat_t       writeData,
    output beat_t       readData,
    output logic        dataOk,
    // memory side
    output logic        arValid,
    input  logic        arReady,
    output addr_t       arAddr,
    input  logic        rValid,
    output logic        rReady,
    input  beat_t       rData,
    input  logic        rLast,
    output logic        awValid,
    input  logic        awReady,
    output addr_t       awAddr,
    output logic        wValid,
    input  logic        wReady,
    output beat_t       wData,
    output beatStrobe_t wStrb,
    output logic        wLast,
    input  logic        bValid,
    output logic        bReady
);

    tag_t        requestTag;
    setIndex_t   requestSet;
    lineOffset_t requestOffset;

    logic       hit;
    way_t       hitWay;
    logic       victimDirty;
    tag_t       victimTag;
    way_t       fillWay;
    way_t       lineWay;
    logic       tagWrite;
    logic       validSet;
    logic       dirtySet;
    logic       dirtyClear;
    logic       storeWrite;
    logic       fillWrite;
    beatIndex_t fillBeat;
    line_t      readLine;

    // address fields
    assign requestTag    = requestAddr[31:8];
    assign requestSet    = requestAddr[7:4];
    assign requestOffset = requestAddr[3:0];

    tagDirectory i_tagDirectory (
        .clock      (clock),
        .reset      (reset),
        .lookupSet  (requestSet),
        .lookupTag  (requestTag),
        .fillWay    (fillWay),
        .tagWrite   (tagWrite),
        .validSet   (validSet),
        .dirtySet   (dirtySet),
        .dirtyClear (dirtyClear),
        .hit        (hit),
        .hitWay     (hitWay),
        .victimDirty(victimDirty),
        .victimTag  (victimTag)
    );

    // refill beats land straight from rData
    lineStore i_lineStore (
        .clock     (clock),
        .lineSet   (requestSet),
        .lineWay   (lineWay),
        .offset    (requestOffset),
        .size      (requestSize),
        .storeData (writeData),
        .storeWrite(storeWrite),
        .fillWrite (fillWrite),
        .fillBeat  (fillBeat),
        .fillData  (rData),
        .readData  (readData),
        .readLine  (readLine)
    );

    missController i_missController (
        .clock       (clock),
        .reset       (reset),
        .requestValid(requestValid),
        .requestOp   (requestOp),
        .requestTag  (requestTag),
        .requestSet  (requestSet),
        .hit         (hit),
        .hitWay      (hitWay),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .readLine    (readLine),
        .arValid     (arValid),
        .arReady     (arReady),
        .arAddr      (arAddr),
        .rValid      (rValid),
        .rReady      (rReady),
        .rLast       (rLast),
        .awValid     (awValid),
        .awReady     (awReady),
        .awAddr      (awAddr),
        .wValid      (wValid),
        .wReady      (wReady),
        .wData       (wData),
        .wStrb       (wStrb),
        .wLast       (wLast),
        .bValid      (bValid),
        .bReady      (bReady),
        .tagWrite    (tagWrite),
        .validSet    (validSet),
        .dirtySet    (dirtySet),
        .dirtyClear  (dirtyClear),
        .fillWay     (fillWay),
        .lineWay     (lineWay),
        .storeWrite  (storeWrite),
        .fillWrite   (fillWrite),
        .fillBeat    (fillBeat),
        .dataOk      (dataOk)
    );

endmodule

//--- axiMemoryModel.sv
`timescale 1ns/100ps

module axiMemoryModel import cacheConfigPkg::*, axiBusPkg::*; #(
    parameter int memWords = 256
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        stallEnable,
    input  logic        arValid,
    output logic        arReady,
    input  addr_t       arAddr,
    output logic        rValid,
    input  logic        rReady,
    output beat_t       rData,
    output logic        rLast,
    input  logic        awValid,
    output logic        awReady,
    input  addr_t       awAddr,
    input  logic        wValid,
    output logic        wReady,
    input  beat_t       wData,
    input  beatStrobe_t wStrb,
    input  logic        wLast,
    output logic        bValid,
    input  logic        bReady
);

    beat_t  mem [memWords];
    int     writeBeats;
    integer seed = 32'h101d;
    logic   readActive;
    logic   writeActive;
    logic   respPending;
    addr_t  readBase;
    addr_t  writeBase;
    int     readBeat;
    int     writeBeat;

    // coin flip per ready or valid, always go without stalls
    function automatic logic go();
        integer r;
        r = $random(seed);
        return !stallEnable || r[0];
    endfunction

    function automatic int beatAddr(input addr_t base, input int beat);
        return int'((base >> 3) % memWords) + beat % beatsPerLine;
    endfunction

    assign rData = mem[beatAddr(readBase, readBeat)];
    assign rLast = (readBeat == beatsPerLine - 1);

    initial begin
        arReady = 1'b0;
        rValid = 1'b0;
        awReady = 1'b0;
        wReady = 1'b0;
        bValid = 1'b0;
        readBase = '0;
        readBeat = 0;
    end

    always @(posedge clock) begin
        if (reset) begin
            arReady <= 1'b0;
            rValid <= 1'b0;
            awReady <= 1'b0;
            wReady <= 1'b0;
            bValid <= 1'b0;
            readActive <= 1'b0;
            writeActive <= 1'b0;
            respPending <= 1'b0;
            writeBeats <= 0;
        end else begin
            // one read burst at a time
            if (arValid && arReady) begin
                readActive <= 1'b1;
                readBase <= arAddr;
                readBeat <= 0;
                arReady <= 1'b0;
            end else begin
                arReady <= !readActive && go();
            end
            // offered beat holds until taken
            if (rValid && rReady) begin
                rValid <= 1'b0;
                readBeat <= readBeat + 1;
                if (rLast) begin
                    readActive <= 1'b0;
                end
            end else if (readActive && !rValid) begin
                rValid <= go();
            end
            if (awValid && awReady) begin
                writeActive <= 1'b1;
                writeBase <= awAddr;
                writeBeat <= 0;
                awReady <= 1'b0;
            end else begin
                awReady <= !writeActive && go();
            end
            // merge under the byte strobes
            if (wValid && wReady) begin
                for (int b = 0; b < beatBytes; b++) begin
                    if (wStrb[b]) begin
                        mem[beatAddr(writeBase, writeBeat)][b*8 +: 8] <= wData[b*8 +: 8];
                    end
                end
                writeBeat <= writeBeat + 1;
                writeBeats <= writeBeats + 1;
                if (wLast) begin
                    respPending <= 1'b1;
                end
            end
            wReady <= writeActive && !respPending && !(wValid && wReady && wLast) && go();
            // response once the last beat is in
            if (bValid && bReady) begin
                bValid <= 1'b0;
                respPending <= 1'b0;
                writeActive <= 1'b0;
            end else if (respPending && !bValid) begin
                bValid <= go();
            end
        end
    end

endmodule

//--- cacheProtocol_props.sv
`timescale 1ns/100ps

module cacheProtocolProps import cacheConfigPkg::*; (
    input logic  clock,
    input logic  reset,
    input logic  arValid,
    input addr_t arAddr,
    input logic  awValid,
    input addr_t awAddr,
    input logic  wValid,
    input logic  wReady,
    input logic  wLast,
    input logic  dataOk
);

    int   assertFailures = 0;
    // high on the second beat of a write burst
    logic wBeat;

    always_ff @(posedge clock) begin
        if (reset) begin
            wBeat <= 1'b0;
        end else if (wValid && wReady) begin
            wBeat <= !wBeat;
        end
    end

    arAligned: assert property (@(posedge clock) disable iff (reset)
        arValid |-> arAddr[3:0] == 4'h0)
        else begin
            assertFailures++;
            $error("read burst address not line aligned");
        end

    awAligned: assert property (@(posedge clock) disable iff (reset)
        awValid |-> awAddr[3:0] == 4'h0)
        else begin
            assertFailures++;
            $error("write burst address not line aligned");
        end

    // wLast only on the closing beat of two
    lastBeat: assert property (@(posedge clock) disable iff (reset)
        (wValid && wReady) |-> (wLast == wBeat))
        else begin
            assertFailures++;
            $error("wLast out of step with the beat count");
        end

    okPulse: assert property (@(posedge clock) disable iff (reset)
        dataOk |=> !dataOk)
        else begin
            assertFailures++;
            $error("dataOk held longer than one cycle");
        end

endmodule

bind dataCache cacheProtocolProps i_cacheProtocolProps (.*);

//--- dataCacheTb.sv
`timescale 1ns/100ps

module dataCacheTb import cacheConfigPkg::*, axiBusPkg::*; ();

    // 256 beats of backing memory, tags 0 to 7 fit
    localparam int memWords = 256;
    localparam int numTests = 5;
    localparam int cyclesPerTest = 400;

    logic        clock;
    logic        reset;
    logic        requestValid;
    cacheOp_e    requestOp;
    addr_t       requestAddr;
    accessSize_e requestSize;
    beat_t       writeData;
    beat_t       readData;
    logic        dataOk;
    logic        stallEnable;
    logic        arValid;
    logic        arReady;
    logic        rValid;
    logic        rReady;
    logic        rLast;
    logic        awValid;
    logic        awReady;
    logic        wValid;
    logic        wReady;
    logic        wLast;
    logic        bValid;
    logic        bReady;
    addr_t       arAddr;
    addr_t       awAddr;
    beat_t       rData;
    beat_t       wData;
    beatStrobe_t wStrb;

    integer seed = 32'h101d;
    int     errorCount = 0;
    // what memory should hold as the requester sees it
    beat_t  expectMem [memWords];
    // set 5 sweep results, replayed under stalls
    beat_t  sweepResults [$];

    dataCache i_dataCache (.*);

    axiMemoryModel #(.memWords(memWords)) i_axiMemoryModel (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic int memIndex(input addr_t addr);
        return int'((addr >> 3) % memWords);
    endfunction

    // 64 bits from the byte offset, zeros past the line end
    function automatic beat_t expectedRead(input addr_t addr);
        line_t line;
        int    base;
        base = memIndex(addr) & ~1;
        line = {expectMem[base + 1], expectMem[base]};
        return beat_t'(line >> (addr[3:0] * 8));
    endfunction

    task automatic checkBeat(input beat_t actual, input beat_t expected, input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic checkCount(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // same random pattern into both copies
    task automatic fillMemory();
        for (int i = 0; i < memWords; i++) begin
            expectMem[i] = {$random(seed), $random(seed)};
            i_axiMemoryModel.mem[i] = expectMem[i];
        end
    endtask

    // request held until dataOk, cycles counted from the drive edge
    task automatic runRequest(input cacheOp_e op, input addr_t addr, input accessSize_e size,
                              input beat_t data, output beat_t result, output int cycles);
        @(posedge clock);
        requestValid <= 1'b1;
        requestOp    <= op;
        requestAddr  <= addr;
        requestSize  <= size;
        writeData    <= data;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
        end while (!dataOk);
        result = readData;
        @(posedge clock);
        requestValid <= 1'b0;
    endtask

    task automatic readAndCompare(input addr_t addr, output beat_t result);
        int cycles;
        runRequest(opRead, addr, sizeDouble, '0, result, cycles);
        checkBeat(result, expectedRead(addr), $sformatf("read of %h", addr));
    endtask

    // store, then merge the same bytes into the expected memory
    task automatic storeBytes(input addr_t addr, input accessSize_e size, input beat_t data);
        beat_t unused;
        int    cycles;
        addr_t a;
        runRequest(opWrite, addr, size, data, unused, cycles);
        for (int i = 0; i < (1 << int'(size)); i++) begin
            a = addr + i;
            expectMem[memIndex(a)][a[2:0]*8 +: 8] = data[i*8 +: 8];
        end
    endtask

    task automatic readMissHit();
        beat_t result;
        int    cycles;
        runRequest(opRead, 32'h0000_0128, sizeDouble, '0, result, cycles);
        checkBeat(result, expectedRead(32'h0000_0128), "read miss");
        runRequest(opRead, 32'h0000_0120, sizeDouble, '0, result, cycles);
        checkBeat(result, expectedRead(32'h0000_0120), "read hit");
        checkCount(cycles, 2, "hit latency");
    endtask

    task automatic mergeWrites();
        beat_t result;
        storeBytes(32'h0000_0231, sizeByte, 64'h0000_0000_0000_00a5);
        readAndCompare(32'h0000_0230, result);
        storeBytes(32'h0000_0236, sizeHalf, 64'h0000_0000_0000_beef);
        readAndCompare(32'h0000_0230, result);
        storeBytes(32'h0000_023c, sizeWord, 64'h0000_0000_1234_5678);
        readAndCompare(32'h0000_0238, result);
        storeBytes(32'h0000_0238, sizeDouble, 64'h0bad_cafe_f00d_d00d);
        readAndCompare(32'h0000_0238, result);
    endtask

    // five tags into four ways, two passes
    task automatic sweepSet(input bit replay);
        beat_t result;
        addr_t addr;
        int    k;
        k = 0;
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 0; t < 5; t++) begin
                addr = (addr_t'(t) << 8) | 32'h0000_0054;
                readAndCompare(addr, result);
                if (replay) begin
                    checkBeat(result, sweepResults[k], "replay under stalls");
                end else begin
                    sweepResults.push_back(result);
                end
                k++;
            end
        end
    endtask

    task automatic dirtyWriteback(input setIndex_t set);
        beat_t result;
        addr_t addr;
        int    beatsBefore;
        int    written;
        beatsBefore = i_axiMemoryModel.writeBeats;
        written = 0;
        for (int t = 0; t < 5; t++) begin
            addr = (addr_t'(t) << 8) | (addr_t'(set) << 4);
            storeBytes(addr, sizeDouble, {32'h5eed_0000 | set, 32'h0000_b000 | t});
        end
        // evicted lines carry the stored beat, the rest still the old data
        for (int t = 0; t < 5; t++) begin
            addr = (addr_t'(t) << 8) | (addr_t'(set) << 4);
            if (i_axiMemoryModel.mem[memIndex(addr)] == expectMem[memIndex(addr)]) begin
                written++;
            end
            checkBeat(i_axiMemoryModel.mem[memIndex(addr) + 1], expectMem[memIndex(addr) + 1],
                      "upper beat after write-back");
        end
        checkCount(i_axiMemoryModel.writeBeats - beatsBefore, written * beatsPerLine,
                   "write beats");
        checkCount(int'(written > 0), 1, "dirty line evicted");
        for (int t = 0; t < 5; t++) begin
            addr = (addr_t'(t) << 8) | (addr_t'(set) << 4);
            readAndCompare(addr, result);
        end
    endtask

    task automatic stalledTraffic();
        @(posedge clock);
        stallEnable <= 1'b1;
        sweepSet(1'b1);
        // also drives aw, w and b under stalls
        dirtyWriteback(4'd9);
        @(posedge clock);
        stallEnable <= 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        requestValid = 1'b0;
        requestOp = opRead;
        requestAddr = '0;
        requestSize = sizeByte;
        writeData = '0;
        stallEnable = 1'b0;
        fillMemory();
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        readMissHit();
        mergeWrites();
        sweepSet(1'b0);
        dirtyWriteback(4'd7);
        stalledTraffic();
        repeat (2) @(posedge clock);
        $display("checks failed: %0d, assertions failed: %0d", errorCount,
                 i_dataCache.i_cacheProtocolProps.assertFailures);
        if (errorCount == 0 && i_dataCache.i_cacheProtocolProps.assertFailures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // run limit scales with the number of tests
    initial begin
        repeat (numTests * cyclesPerTest) @(posedge clock);
        $display("timeout after %0t, the cache stopped answering requests", $time);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- compile.f
cacheConfigPkg.sv
axiBusPkg.sv
tagDirectory.sv
lineStore.sv
missController.sv
dataCache.sv
axiMemoryModel.sv
cacheProtocol_props.sv
dataCacheTb.sv

//--- Bender.yml
package:
  name: dataCache

sources:
  - cacheConfigPkg.sv
  - axiBusPkg.sv
  - tagDirectory.sv
  - lineStore.sv
  - missController.sv
  - dataCache.sv
  - target: test
    files:
      - axiMemoryModel.sv
      - cacheProtocol_props.sv
      - dataCacheTb.sv
